/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module csr_unit_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vcsr_unit_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1

/* sim/csr_unit_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_unit_tb;

	localparam logic [31:0] VENDOR_ID = 32'h0000_0A5C;
	localparam logic [31:0] ARCH_ID   = 32'h0000_0019;
	localparam logic [31:0] IMP_ID    = 32'h0003_0201;
	localparam logic [31:0] HART_ID   = 32'h0000_0002;
	localparam logic [11:0] CSR_UNKNOWN = 12'h7C0;
	// about 80 handshakes of six cycles and a few interrupt pulses leave wide margin.
	localparam int MAX_CYCLES = 4000;

	logic        clock = 1'b0;
	logic        reset;
	logic        req;
	logic [31:0] instr;
	logic [31:0] rs1_value;
	logic        timer_irq;
	logic        external_irq;
	logic        dispatched;
	logic [31:0] irq_epc;
	logic        ack;
	logic [4:0]  rd_index;
	logic [31:0] rd_value;
	logic        rd_write;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        illegal;
	logic        irq_pending;
	logic [31:0] irq_pc;

	// reference state of the csr file.
	csr_pkg::csr_word_u model_mie;
	csr_pkg::csr_word_u model_mip;
	logic [31:0]        model_mtvec;
	logic [31:0]        model_mepc;
	logic [31:0]        model_mcause;
	logic               model_pending;
	logic [31:0]        model_irq_pc;

	logic [31:0] exp_rd_value;
	logic [4:0]  exp_rd_index;
	logic        exp_rd_write;
	logic        exp_redirect;
	logic [31:0] exp_redirect_pc;
	logic        exp_illegal;

	logic   ack_seen = 1'b0;
	int     cycle_count = 0;
	int     check_count = 0;
	int     error_count = 0;
	integer seed;

	csr_unit_top #(
		.VENDOR_ID (VENDOR_ID),
		.ARCH_ID   (ARCH_ID),
		.IMP_ID    (IMP_ID),
		.HART_ID   (HART_ID)
	) DUT (
		.i_clock              (clock),
		.i_reset              (reset),
		.i_req                (req),
		.i_instr              (instr),
		.i_rs1_value          (rs1_value),
		.o_ack                (ack),
		.o_rd_index           (rd_index),
		.o_rd_value           (rd_value),
		.o_rd_write           (rd_write),
		.o_redirect           (redirect),
		.o_redirect_pc        (redirect_pc),
		.o_illegal            (illegal),
		.i_timer_interrupt    (timer_irq),
		.i_external_interrupt (external_irq),
		.i_irq_dispatched     (dispatched),
		.i_irq_epc            (irq_epc),
		.o_irq_pending        (irq_pending),
		.o_irq_pc             (irq_pc)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] encode_instr(input logic [11:0] csr, input logic [4:0] rs1,
			input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
		csr_pkg::csr_instr_t word;
		word.csr = csr;
		word.rs1 = rs1;
		word.funct3 = funct3;
		word.rd = rd;
		word.opcode = opcode;
		return word;
	endfunction

	function automatic logic [31:0] read_model(input logic [11:0] index);
		case (index)
			csr_pkg::CSR_MIE:       return model_mie.raw;
			csr_pkg::CSR_MTVEC:     return model_mtvec;
			csr_pkg::CSR_MEPC:      return model_mepc;
			csr_pkg::CSR_MCAUSE:    return model_mcause;
			csr_pkg::CSR_MIP:       return model_mip.raw;
			csr_pkg::CSR_MVENDORID: return VENDOR_ID;
			csr_pkg::CSR_MARCHID:   return ARCH_ID;
			csr_pkg::CSR_MIMPID:    return IMP_ID;
			csr_pkg::CSR_MHARTID:   return HART_ID;
			default:                return 32'd0;
		endcase
	endfunction

	// only mie, mtvec and mepc take writes; mie keeps bits 3, 7 and 11.
	function automatic void write_model(input logic [11:0] index, input logic [31:0] value);
		case (index)
			csr_pkg::CSR_MIE:   model_mie.raw = value & 32'h0000_0888;
			csr_pkg::CSR_MTVEC: model_mtvec = value;
			csr_pkg::CSR_MEPC:  model_mepc = value;
			default: ;
		endcase
	endfunction

	function automatic void reference_model(input logic [31:0] instr_word,
			input logic [31:0] operand_in, output logic [31:0] exp_value,
			output logic exp_write, output logic exp_jump, output logic [31:0] exp_target,
			output logic exp_bad);
		csr_pkg::csr_instr_t ins;
		logic [31:0] old_value;
		logic [31:0] operand;
		logic [31:0] new_value;
		logic        no_regs;
		ins = instr_word;
		no_regs = (ins.rs1 == 5'd0) && (ins.rd == 5'd0);
		exp_value = 32'd0;
		exp_write = 1'b0;
		exp_jump = 1'b0;
		exp_target = 32'd0;
		exp_bad = 1'b0;
		if (ins.opcode != csr_pkg::OPCODE_SYSTEM) begin
			exp_bad = 1'b1;
		end else if (ins.funct3 == 3'b000) begin
			if (no_regs && ins.csr == csr_pkg::FUNCT12_ECALL) begin
				// ecall is also recorded in the software interrupt bit.
				model_mcause = csr_pkg::CAUSE_ECALL;
				model_mip.irq.msip = 1'b1;
				model_pending = 1'b1;
				model_irq_pc = model_mtvec;
			end else if (no_regs && ins.csr == csr_pkg::FUNCT12_MRET) begin
				exp_jump = 1'b1;
				exp_target = model_mepc;
			end else begin
				exp_bad = 1'b1;
			end
		end else if (ins.funct3 == 3'b100) begin
			exp_bad = 1'b1;
		end else begin
			old_value = read_model(ins.csr);
			operand = ins.funct3[2] ? {27'd0, ins.rs1} : operand_in;
			case (ins.funct3[1:0])
				2'b01:   new_value = operand;
				2'b10:   new_value = old_value | operand;
				default: new_value = old_value & ~operand;
			endcase
			if (ins.funct3[1:0] == 2'b01 || ins.rs1 != 5'd0)
				write_model(ins.csr, new_value);
			exp_value = old_value;
			exp_write = (ins.rd != 5'd0);
		end
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		assert (got === expected) else begin
			error_count++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic compare_irq_word(input string name, input csr_pkg::csr_word_u got,
			input csr_pkg::csr_word_u expected);
		compare_value({name, ".raw"}, got.raw, expected.raw);
		compare_value({name, ".meip"}, {31'd0, got.irq.meip}, {31'd0, expected.irq.meip});
		compare_value({name, ".mtip"}, {31'd0, got.irq.mtip}, {31'd0, expected.irq.mtip});
		compare_value({name, ".msip"}, {31'd0, got.irq.msip}, {31'd0, expected.irq.msip});
	endtask

	task automatic irq_state_check();
		compare_value("o_irq_pending", {31'd0, irq_pending}, {31'd0, model_pending});
		if (model_pending)
			compare_value("o_irq_pc", irq_pc, model_irq_pc);
	endtask

	// one full four-phase handshake.
	task automatic issue_instr(input logic [31:0] word, input logic [31:0] operand);
		reference_model(word, operand, exp_rd_value, exp_rd_write, exp_redirect,
			exp_redirect_pc, exp_illegal);
		exp_rd_index = word[11:7];
		@(posedge clock);
		req <= 1'b1;
		instr <= word;
		rs1_value <= operand;
		do @(posedge clock); while (!ack);
		req <= 1'b0;
		do @(posedge clock); while (ack);
	endtask

	// a zero rs1 field must keep the all-ones register operand from being written.
	task automatic read_csr(input logic [11:0] index, output logic [31:0] value);
		issue_instr(encode_instr(index, 5'd0, csr_pkg::FUNCT3_CSRRS, 5'd1,
			csr_pkg::OPCODE_SYSTEM), 32'hFFFF_FFFF);
		value = rd_value;
	endtask

	task automatic write_csr(input logic [11:0] index, input logic [31:0] value);
		issue_instr(encode_instr(index, 5'd1, csr_pkg::FUNCT3_CSRRW, 5'd0,
			csr_pkg::OPCODE_SYSTEM), value);
	endtask

	task automatic pulse_interrupts(input logic timer, input logic external);
		logic take_timer;
		logic take_external;
		take_timer = timer && model_mie.irq.mtip;
		take_external = external && model_mie.irq.meip;
		@(posedge clock);
		timer_irq <= timer;
		external_irq <= external;
		@(posedge clock);
		timer_irq <= 1'b0;
		external_irq <= 1'b0;
		@(posedge clock);
		if (take_external)
			model_mcause = csr_pkg::CAUSE_EXTERNAL;
		else if (take_timer)
			model_mcause = csr_pkg::CAUSE_TIMER;
		if (take_external)
			model_mip.irq.meip = 1'b1;
		if (take_timer)
			model_mip.irq.mtip = 1'b1;
		if (take_timer || take_external) begin
			model_pending = 1'b1;
			model_irq_pc = model_mtvec;
		end
		irq_state_check();
	endtask

	task automatic dispatch_trap(input logic [31:0] epc);
		@(posedge clock);
		dispatched <= 1'b1;
		irq_epc <= epc;
		@(posedge clock);
		dispatched <= 1'b0;
		@(posedge clock);
		model_pending = 1'b0;
		model_mepc = epc;
		model_mip.raw = 32'd0;
		irq_state_check();
	endtask

	// outputs are sampled one edge after ack rises while they are held.
	always @(posedge clock) begin
		ack_seen <= ack;
		if (ack && !ack_seen) begin
			compare_value("o_illegal", {31'd0, illegal}, {31'd0, exp_illegal});
			compare_value("o_rd_write", {31'd0, rd_write}, {31'd0, exp_rd_write});
			compare_value("o_redirect", {31'd0, redirect}, {31'd0, exp_redirect});
			if (exp_rd_write) begin
				compare_value("o_rd_value", rd_value, exp_rd_value);
				compare_value("o_rd_index", {27'd0, rd_index}, {27'd0, exp_rd_index});
			end
			if (exp_redirect)
				compare_value("o_redirect_pc", redirect_pc, exp_redirect_pc);
			irq_state_check();
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("%0d checks, %0d errors", check_count, error_count);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		logic [31:0]        rnd;
		logic [31:0]        value;
		logic [11:0]        index;
		logic [2:0]         funct3;
		logic [4:0]         rs1_field;
		logic [4:0]         rd_field;
		csr_pkg::csr_word_u word;
		seed = 18880;
		reset = 1'b1;
		req = 1'b0;
		instr = 32'd0;
		rs1_value = 32'd0;
		timer_irq = 1'b0;
		external_irq = 1'b0;
		dispatched = 1'b0;
		irq_epc = 32'd0;
		model_mie.raw = 32'd0;
		model_mip.raw = 32'd0;
		model_mtvec = 32'd0;
		model_mepc = 32'd0;
		model_mcause = 32'd0;
		model_pending = 1'b0;
		model_irq_pc = 32'd0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		// identity, reset values, unknown index, ignored writes.
		read_csr(csr_pkg::CSR_MVENDORID, value);
		read_csr(csr_pkg::CSR_MARCHID, value);
		read_csr(csr_pkg::CSR_MIMPID, value);
		read_csr(csr_pkg::CSR_MHARTID, value);
		read_csr(csr_pkg::CSR_MIE, value);
		read_csr(csr_pkg::CSR_MTVEC, value);
		read_csr(csr_pkg::CSR_MEPC, value);
		read_csr(csr_pkg::CSR_MCAUSE, value);
		read_csr(csr_pkg::CSR_MIP, value);
		read_csr(CSR_UNKNOWN, value);
		write_csr(csr_pkg::CSR_MVENDORID, 32'hFFFF_FFFF);
		write_csr(csr_pkg::CSR_MCAUSE, 32'hFFFF_FFFF);
		write_csr(CSR_UNKNOWN, 32'hFFFF_FFFF);
		read_csr(csr_pkg::CSR_MVENDORID, value);
		read_csr(csr_pkg::CSR_MCAUSE, value);
		read_csr(CSR_UNKNOWN, value);

		// random read-modify-write traffic.
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd0:    index = csr_pkg::CSR_MTVEC;
				2'd1:    index = csr_pkg::CSR_MEPC;
				default: index = csr_pkg::CSR_MIE;
			endcase
			funct3 = rnd[4:2];
			if (funct3[1:0] == 2'b00)
				funct3[0] = 1'b1;
			rs1_field = rnd[9:5];
			if (i % 5 == 0)
				rs1_field = 5'd0;
			rd_field = rnd[14:10];
			issue_instr(encode_instr(index, rs1_field, funct3, rd_field,
				csr_pkg::OPCODE_SYSTEM), $random(seed));
		end
		read_csr(csr_pkg::CSR_MTVEC, value);
		read_csr(csr_pkg::CSR_MEPC, value);
		read_csr(csr_pkg::CSR_MIE, value);

		write_csr(csr_pkg::CSR_MIE, 32'hFFFF_FFFF);
		read_csr(csr_pkg::CSR_MIE, value);
		word.raw = value;
		compare_irq_word("mie", word, model_mie);

		// enabled interrupts, one at a time.
		write_csr(csr_pkg::CSR_MTVEC, 32'h0000_4000);
		pulse_interrupts(1'b1, 1'b0);
		read_csr(csr_pkg::CSR_MCAUSE, value);
		read_csr(csr_pkg::CSR_MIP, value);
		word.raw = value;
		compare_irq_word("mip", word, model_mip);
		dispatch_trap(32'h0000_0100);
		pulse_interrupts(1'b0, 1'b1);
		read_csr(csr_pkg::CSR_MCAUSE, value);
		read_csr(csr_pkg::CSR_MIP, value);
		word.raw = value;
		compare_irq_word("mip", word, model_mip);
		dispatch_trap(32'h0000_0200);

		// disabled interrupts, then both at once.
		issue_instr(encode_instr(csr_pkg::CSR_MIE, 5'd2, csr_pkg::FUNCT3_CSRRC, 5'd0,
			csr_pkg::OPCODE_SYSTEM), 32'h0000_0880);
		pulse_interrupts(1'b1, 1'b0);
		pulse_interrupts(1'b0, 1'b1);
		issue_instr(encode_instr(csr_pkg::CSR_MIE, 5'd2, csr_pkg::FUNCT3_CSRRS, 5'd0,
			csr_pkg::OPCODE_SYSTEM), 32'h0000_0880);
		pulse_interrupts(1'b1, 1'b1);
		read_csr(csr_pkg::CSR_MCAUSE, value);
		read_csr(csr_pkg::CSR_MIP, value);
		word.raw = value;
		compare_irq_word("mip", word, model_mip);
		dispatch_trap(32'h0000_0300);

		// ecall, dispatch, mret.
		issue_instr(encode_instr(csr_pkg::FUNCT12_ECALL, 5'd0, 3'b000, 5'd0,
			csr_pkg::OPCODE_SYSTEM), 32'd0);
		read_csr(csr_pkg::CSR_MCAUSE, value);
		dispatch_trap(32'h2468_ACE0);
		read_csr(csr_pkg::CSR_MIP, value);
		read_csr(csr_pkg::CSR_MEPC, value);
		issue_instr(encode_instr(csr_pkg::FUNCT12_MRET, 5'd0, 3'b000, 5'd0,
			csr_pkg::OPCODE_SYSTEM), 32'd0);

		// illegal encodings leave the csr file alone.
		issue_instr(encode_instr(csr_pkg::CSR_MTVEC, 5'd3, csr_pkg::FUNCT3_CSRRW, 5'd5,
			7'b0110011), 32'hDEAD_BEEF);
		issue_instr(encode_instr(csr_pkg::CSR_MTVEC, 5'd3, 3'b100, 5'd4,
			csr_pkg::OPCODE_SYSTEM), 32'hDEAD_BEEF);
		read_csr(csr_pkg::CSR_MTVEC, value);

		repeat (2) @(posedge clock);
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* source/csr_decode.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_decode (
	input  csr_pkg::csr_instr_t i_instr,
	input  logic [31:0]         i_rs1_value,
	output csr_pkg::csr_op_e    o_op,
	output logic [11:0]         o_index,
	output logic [31:0]         o_operand,
	output logic                o_suppress_write,
	output logic [4:0]          o_rd_index
);

	logic is_system;
	logic no_regs;

	assign is_system = (i_instr.opcode == csr_pkg::OPCODE_SYSTEM);
	// ecall and mret carry zero in rs1 and rd.
	assign no_regs = (i_instr.rs1 == 5'd0) && (i_instr.rd == 5'd0);

	always_comb begin
		o_op = csr_pkg::OP_ILLEGAL;
		if (is_system) begin
			case (i_instr.funct3)
				csr_pkg::FUNCT3_CSRRW, csr_pkg::FUNCT3_CSRRWI: o_op = csr_pkg::OP_WRITE;
				csr_pkg::FUNCT3_CSRRS, csr_pkg::FUNCT3_CSRRSI: o_op = csr_pkg::OP_SET;
				csr_pkg::FUNCT3_CSRRC, csr_pkg::FUNCT3_CSRRCI: o_op = csr_pkg::OP_CLEAR;
				3'b000: begin
					if (no_regs && i_instr.csr == csr_pkg::FUNCT12_ECALL)
						o_op = csr_pkg::OP_ECALL;
					else if (no_regs && i_instr.csr == csr_pkg::FUNCT12_MRET)
						o_op = csr_pkg::OP_MRET;
				end
				default: o_op = csr_pkg::OP_ILLEGAL;
			endcase
		end
	end

	assign o_index = i_instr.csr;
	assign o_rd_index = i_instr.rd;

	// funct3[2] marks the immediate forms.
	assign o_operand = i_instr.funct3[2] ? {27'd0, i_instr.rs1} : i_rs1_value;

	// set and clear with rs1 field zero only read.
	assign o_suppress_write = ((o_op == csr_pkg::OP_SET) || (o_op == csr_pkg::OP_CLEAR))
		&& (i_instr.rs1 == 5'd0);

endmodule

`default_nettype wire

/* source/csr_execute.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_execute #(
	parameter logic [31:0] VENDOR_ID = 32'h0,
	parameter logic [31:0] ARCH_ID   = 32'h0,
	parameter logic [31:0] IMP_ID    = 32'h0,
	parameter logic [31:0] HART_ID   = 32'h0
) (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_req,
	input  csr_pkg::csr_op_e    i_op,
	input  logic [11:0]         i_index,
	input  logic [31:0]         i_operand,
	input  logic                i_suppress_write,
	input  logic [4:0]          i_rd_index,
	input  logic                i_timer_interrupt,
	input  logic                i_external_interrupt,
	input  logic                i_irq_dispatched,
	input  logic [31:0]         i_irq_epc,
	output logic                o_irq_pending,
	output logic [31:0]         o_irq_pc,
	csr_result_if.execute       result
);

	typedef enum logic {
		ST_IDLE,
		ST_ACCESS
	} state_e;

	state_e state;

	csr_pkg::csr_op_e op_q;
	logic [11:0]      index_q;
	logic [31:0]      operand_q;
	logic             suppress_q;
	logic [4:0]       rd_index_q;
	logic             is_csr_op;
	logic             active;

	csr_bus_if bus ();

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
		end else if (state == ST_IDLE) begin
			if (i_req && !result.busy)
				state <= ST_ACCESS;
		end else begin
			state <= ST_IDLE;
		end
	end

	// request fields, captured when the access starts.
	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE && i_req && !result.busy) begin
			op_q <= i_op;
			index_q <= i_index;
			operand_q <= i_operand;
			suppress_q <= i_suppress_write;
			rd_index_q <= i_rd_index;
		end
	end

	assign active = (state == ST_ACCESS);
	assign is_csr_op = (op_q == csr_pkg::OP_WRITE) || (op_q == csr_pkg::OP_SET)
		|| (op_q == csr_pkg::OP_CLEAR);

	// mret fetches its return address through the same read port.
	assign bus.index = (op_q == csr_pkg::OP_MRET) ? csr_pkg::CSR_MEPC : index_q;
	assign bus.write = active && is_csr_op && !suppress_q;
	assign bus.ecall = active && (op_q == csr_pkg::OP_ECALL);

	always_comb begin
		case (op_q)
			csr_pkg::OP_WRITE: bus.wdata = operand_q;
			csr_pkg::OP_SET:   bus.wdata = bus.rdata | operand_q;
			csr_pkg::OP_CLEAR: bus.wdata = bus.rdata & ~operand_q;
			default:           bus.wdata = bus.rdata;
		endcase
	end

	assign result.valid = active;
	assign result.rd_index = rd_index_q;
	assign result.rd_value = bus.rdata;
	assign result.rd_write = is_csr_op && (rd_index_q != 5'd0);
	assign result.redirect = (op_q == csr_pkg::OP_MRET);
	assign result.redirect_pc = bus.rdata;
	assign result.illegal = (op_q == csr_pkg::OP_ILLEGAL);

	csr_file #(
		.VENDOR_ID (VENDOR_ID),
		.ARCH_ID   (ARCH_ID),
		.IMP_ID    (IMP_ID),
		.HART_ID   (HART_ID)
	) u_csr_file (
		.i_clock              (i_clock),
		.i_reset              (i_reset),
		.i_timer_interrupt    (i_timer_interrupt),
		.i_external_interrupt (i_external_interrupt),
		.i_irq_dispatched     (i_irq_dispatched),
		.i_irq_epc            (i_irq_epc),
		.o_irq_pending        (o_irq_pending),
		.o_irq_pc             (o_irq_pc),
		.bus                  (bus.file)
	);

endmodule

`default_nettype wire

/* source/csr_file.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_file #(
	parameter logic [31:0] VENDOR_ID = 32'h0,
	parameter logic [31:0] ARCH_ID   = 32'h0,
	parameter logic [31:0] IMP_ID    = 32'h0,
	parameter logic [31:0] HART_ID   = 32'h0
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_timer_interrupt,
	input  logic        i_external_interrupt,
	input  logic        i_irq_dispatched,
	input  logic [31:0] i_irq_epc,
	output logic        o_irq_pending,
	output logic [31:0] o_irq_pc,
	csr_bus_if.file     bus
);

	csr_pkg::csr_word_u mie;
	csr_pkg::csr_word_u mip;
	logic [31:0]        mtvec;
	logic [31:0]        mepc;
	logic [31:0]        mcause;

	logic take_ecall;
	logic take_external;
	logic take_timer;
	logic dispatched_q;
	logic dispatch_edge;

	always_comb begin
		case (bus.index)
			csr_pkg::CSR_MIE:       bus.rdata = mie.raw;
			csr_pkg::CSR_MTVEC:     bus.rdata = mtvec;
			csr_pkg::CSR_MEPC:      bus.rdata = mepc;
			csr_pkg::CSR_MCAUSE:    bus.rdata = mcause;
			csr_pkg::CSR_MIP:       bus.rdata = mip.raw;
			csr_pkg::CSR_MVENDORID: bus.rdata = VENDOR_ID;
			csr_pkg::CSR_MARCHID:   bus.rdata = ARCH_ID;
			csr_pkg::CSR_MIMPID:    bus.rdata = IMP_ID;
			csr_pkg::CSR_MHARTID:   bus.rdata = HART_ID;
			default:                bus.rdata = 32'd0;
		endcase
	end

	// ecall traps unconditionally, interrupts only when enabled.
	assign take_ecall = bus.ecall;
	assign take_external = i_external_interrupt && mie.irq.meip;
	assign take_timer = i_timer_interrupt && mie.irq.mtip;

	assign dispatch_edge = i_irq_dispatched && !dispatched_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mie.raw <= 32'd0;
			mip.raw <= 32'd0;
			mtvec <= 32'd0;
			mepc <= 32'd0;
			mcause <= 32'd0;
			o_irq_pending <= 1'b0;
			o_irq_pc <= 32'd0;
			dispatched_q <= 1'b0;
		end else begin
			if (bus.write) begin
				case (bus.index)
					csr_pkg::CSR_MIE: begin
						// only the three enable bits exist.
						mie.irq.meip <= bus.wdata[11];
						mie.irq.mtip <= bus.wdata[7];
						mie.irq.msip <= bus.wdata[3];
					end
					csr_pkg::CSR_MTVEC: mtvec <= bus.wdata;
					csr_pkg::CSR_MEPC:  mepc <= bus.wdata;
					default: ;
				endcase
			end

			if (take_ecall || take_external || take_timer) begin
				o_irq_pending <= 1'b1;
				o_irq_pc <= mtvec;
			end

			if (take_ecall)
				mcause <= csr_pkg::CAUSE_ECALL;
			else if (take_external)
				mcause <= csr_pkg::CAUSE_EXTERNAL;
			else if (take_timer)
				mcause <= csr_pkg::CAUSE_TIMER;

			if (take_ecall)
				mip.irq.msip <= 1'b1;
			if (take_external)
				mip.irq.meip <= 1'b1;
			if (take_timer)
				mip.irq.mtip <= 1'b1;

			dispatched_q <= i_irq_dispatched;

			// dispatch wins over a trap or a mepc write in the same cycle.
			if (dispatch_edge) begin
				o_irq_pending <= 1'b0;
				mepc <= i_irq_epc;
				mip.raw <= 32'd0;
			end
		end
	end

endmodule

`default_nettype wire

/* source/csr_interfaces.sv */
`default_nettype none
`timescale 1ns/100ps

// register access between execute and the csr file.
interface csr_bus_if;
	logic [11:0] index;
	logic        write;
	logic [31:0] wdata;
	logic        ecall;
	logic [31:0] rdata;

	modport execute (output index, output write, output wdata, output ecall, input rdata);
	modport file (input index, input write, input wdata, input ecall, output rdata);
endinterface

// outcome of one instruction, from execute to the result stage.
interface csr_result_if;
	logic        valid;
	logic [4:0]  rd_index;
	logic [31:0] rd_value;
	logic        rd_write;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        illegal;
	logic        busy;

	modport execute (
		output valid, output rd_index, output rd_value, output rd_write,
		output redirect, output redirect_pc, output illegal,
		input busy
	);

	modport result (
		input valid, input rd_index, input rd_value, input rd_write,
		input redirect, input redirect_pc, input illegal,
		output busy
	);
endinterface

`default_nettype wire

/* source/csr_pkg.sv */
`default_nettype none

package csr_pkg;

	// machine-mode csr addresses.
	localparam logic [11:0] CSR_MIE       = 12'h304;
	localparam logic [11:0] CSR_MTVEC     = 12'h305;
	localparam logic [11:0] CSR_MEPC      = 12'h341;
	localparam logic [11:0] CSR_MCAUSE    = 12'h342;
	localparam logic [11:0] CSR_MIP       = 12'h344;
	localparam logic [11:0] CSR_MVENDORID = 12'hF11;
	localparam logic [11:0] CSR_MARCHID   = 12'hF12;
	localparam logic [11:0] CSR_MIMPID    = 12'hF13;
	localparam logic [11:0] CSR_MHARTID   = 12'hF14;

	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

	localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
	localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
	localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
	localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
	localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
	localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

	localparam logic [11:0] FUNCT12_ECALL = 12'h000;
	localparam logic [11:0] FUNCT12_MRET  = 12'h302;

	typedef enum logic [2:0] {
		OP_WRITE,
		OP_SET,
		OP_CLEAR,
		OP_ECALL,
		OP_MRET,
		OP_ILLEGAL
	} csr_op_e;

	// i-type layout; csr is funct12 for ecall and mret.
	typedef struct packed {
		logic [11:0] csr;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} csr_instr_t;

	typedef struct packed {
		logic [19:0] reserved_31_12;
		logic        meip;
		logic [2:0]  reserved_10_8;
		logic        mtip;
		logic [2:0]  reserved_6_4;
		logic        msip;
		logic [2:0]  reserved_2_0;
	} csr_irq_bits_t;

	// mie and mip, seen as a word or as interrupt bits.
	typedef union packed {
		logic [31:0]   raw;
		csr_irq_bits_t irq;
	} csr_word_u;

	localparam logic [31:0] CAUSE_TIMER    = 32'h8000_0007;
	localparam logic [31:0] CAUSE_EXTERNAL = 32'h8000_000B;
	localparam logic [31:0] CAUSE_ECALL    = 32'h0000_000B;

endpackage

`default_nettype wire

/* source/csr_result.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_result (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_req,
	output logic        o_ack,
	output logic [4:0]  o_rd_index,
	output logic [31:0] o_rd_value,
	output logic        o_rd_write,
	output logic        o_redirect,
	output logic [31:0] o_redirect_pc,
	output logic        o_illegal,
	csr_result_if.result result
);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ack <= 1'b0;
			o_rd_write <= 1'b0;
			o_redirect <= 1'b0;
			o_illegal <= 1'b0;
		end else if (result.valid) begin
			o_ack <= 1'b1;
			o_rd_write <= result.rd_write;
			o_redirect <= result.redirect;
			o_illegal <= result.illegal;
		end else if (o_ack && !i_req) begin
			// issuer has let go, close the handshake.
			o_ack <= 1'b0;
			o_rd_write <= 1'b0;
			o_redirect <= 1'b0;
			o_illegal <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (result.valid) begin
			o_rd_index <= result.rd_index;
			o_rd_value <= result.rd_value;
			o_redirect_pc <= result.redirect_pc;
		end
	end

	assign result.busy = o_ack;

endmodule

`default_nettype wire

/* source/csr_unit_top.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_unit_top #(
	parameter logic [31:0] VENDOR_ID = 32'h0,
	parameter logic [31:0] ARCH_ID   = 32'h0,
	parameter logic [31:0] IMP_ID    = 32'h0,
	parameter logic [31:0] HART_ID   = 32'h0
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_req,
	input  logic [31:0] i_instr,
	input  logic [31:0] i_rs1_value,
	output logic        o_ack,
	output logic [4:0]  o_rd_index,
	output logic [31:0] o_rd_value,
	output logic        o_rd_write,
	output logic        o_redirect,
	output logic [31:0] o_redirect_pc,
	output logic        o_illegal,
	input  logic        i_timer_interrupt,
	input  logic        i_external_interrupt,
	input  logic        i_irq_dispatched,
	input  logic [31:0] i_irq_epc,
	output logic        o_irq_pending,
	output logic [31:0] o_irq_pc
);

	csr_pkg::csr_op_e op;
	logic [11:0]      index;
	logic [31:0]      operand;
	logic             suppress_write;
	logic [4:0]       rd_index;

	csr_result_if result_bus ();

	csr_decode u_decode (
		.i_instr          (i_instr),
		.i_rs1_value      (i_rs1_value),
		.o_op             (op),
		.o_index          (index),
		.o_operand        (operand),
		.o_suppress_write (suppress_write),
		.o_rd_index       (rd_index)
	);

	csr_execute #(
		.VENDOR_ID (VENDOR_ID),
		.ARCH_ID   (ARCH_ID),
		.IMP_ID    (IMP_ID),
		.HART_ID   (HART_ID)
	) u_execute (
		.i_clock              (i_clock),
		.i_reset              (i_reset),
		.i_req                (i_req),
		.i_op                 (op),
		.i_index              (index),
		.i_operand            (operand),
		.i_suppress_write     (suppress_write),
		.i_rd_index           (rd_index),
		.i_timer_interrupt    (i_timer_interrupt),
		.i_external_interrupt (i_external_interrupt),
		.i_irq_dispatched     (i_irq_dispatched),
		.i_irq_epc            (i_irq_epc),
		.o_irq_pending        (o_irq_pending),
		.o_irq_pc             (o_irq_pc),
		.result               (result_bus.execute)
	);

	csr_result u_result (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_req         (i_req),
		.o_ack         (o_ack),
		.o_rd_index    (o_rd_index),
		.o_rd_value    (o_rd_value),
		.o_rd_write    (o_rd_write),
		.o_redirect    (o_redirect),
		.o_redirect_pc (o_redirect_pc),
		.o_illegal     (o_illegal),
		.result        (result_bus.result)
	);

endmodule

`default_nettype wire

/* sources.f */
source/csr_pkg.sv
source/csr_interfaces.sv
source/csr_decode.sv
source/csr_file.sv
source/csr_execute.sv
source/csr_result.sv
source/csr_unit_top.sv
sim/csr_unit_tb.sv
